//--- verilog/agc_pkg.sv
package agc_pkg;

    // lane widths
    localparam int SAMPLE_BITS = 12;
    localparam int OUT_BITS    = 5;
    localparam int ABS_BITS    = OUT_BITS - 1;
    // gain is unsigned with 16 fractional bits
    localparam int SCALE_BITS  = 17;
    localparam int OFFSET_BITS = 16;
    // accumulator widths
    localparam int SQ_BITS     = 25;
    localparam int PR_BITS     = 21;

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;
    typedef logic signed [OUT_BITS-1:0]    out_t;
    typedef logic        [ABS_BITS-1:0]    abs_t;
    typedef logic        [SCALE_BITS-1:0]  scale_t;
    typedef logic signed [OFFSET_BITS-1:0] offset_t;
    typedef logic        [SQ_BITS-1:0]     sq_acc_t;
    typedef logic        [PR_BITS-1:0]     pr_acc_t;

    // symmetric clamp and probit threshold, both magnitudes
    localparam int OUT_MAX      = 15;
    localparam int PROBIT_LEVEL = 8;
    localparam int GAIN_SHIFT   = 16;
    localparam scale_t SCALE_UNITY = scale_t'(1 << GAIN_SHIFT);
    localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage

//--- verilog/agc_reg_pkg.sv
package agc_reg_pkg;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t AXIL_OKAY = 2'b00;

    // register map, byte offsets
    // ctrl: bit0 enable, bit1 apply (self clearing, reads back 0)
    localparam axil_addr_t REG_CTRL   = 8'h00;
    localparam axil_addr_t REG_SCALE  = 8'h04;
    localparam axil_addr_t REG_OFFSET = 8'h08;
    // accumulator readback
    localparam axil_addr_t REG_SQ     = 8'h0C;
    localparam axil_addr_t REG_GT     = 8'h10;
    localparam axil_addr_t REG_LT     = 8'h14;

    // bus FSM, one transaction in flight
    typedef enum logic [1:0] {AXIL_IDLE, AXIL_WRESP, AXIL_RDATA} axil_state_e;

endpackage

//--- verilog/agc_cfg_if.sv
`timescale 1ns/10ps

interface agc_cfg_if import agc_pkg::*; ();

    // pending values, valid while their load strobe is high
    scale_t  scale;
    offset_t offset;
    // one-cycle strobes
    logic    scale_load;
    logic    offset_load;
    // copies pending into active in every lane
    logic    apply;
    // level, zero forces lane outputs and flags low
    logic    enable;

    modport regs (
        output scale, offset, scale_load, offset_load, apply, enable
    );

    modport core (
        input  scale, offset, scale_load, offset_load, apply, enable
    );

endinterface

//--- verilog/agc_dsp.sv
`timescale 1ns/10ps

module agc_dsp import agc_pkg::*; (
    input  logic    clk_i,
    input  logic    agc_rst_i,
    agc_cfg_if.core cfg,
    input  sample_t dat_i,
    output out_t    out_o,
    output abs_t    abs_o,
    output logic    gt_o,
    output logic    lt_o
);

    // one guard bit on the offset sum, product keeps sign of the sum
    localparam int SUM_BITS  = OFFSET_BITS + 1;
    localparam int PROD_BITS = SUM_BITS + SCALE_BITS + 1;

    scale_t                      scale_pend_q;
    scale_t                      scale_act_q;
    offset_t                     offset_pend_q;
    offset_t                     offset_act_q;
    logic signed [SUM_BITS-1:0]  sum_q;
    scale_t                      scale_s1_q;
    logic signed [PROD_BITS-1:0] prod_q;
    logic signed [PROD_BITS-1:0] shifted;
    out_t                        sat;
    abs_t                        mag;

    // double buffered gain and offset
    always_ff @(posedge clk_i) begin
        if (agc_rst_i) begin
            scale_pend_q  <= SCALE_UNITY;
            scale_act_q   <= SCALE_UNITY;
            offset_pend_q <= '0;
            offset_act_q  <= '0;
        end else begin
            if (cfg.scale_load)
                scale_pend_q <= cfg.scale;
            if (cfg.offset_load)
                offset_pend_q <= cfg.offset;
            if (cfg.apply) begin
                scale_act_q  <= scale_pend_q;
                offset_act_q <= offset_pend_q;
            end
        end
    end

    // stage 1 offset add, gain travels with the sample so a change lands cleanly
    // stage 2 multiply, gain forced positive
    always_ff @(posedge clk_i) begin
        sum_q      <= dat_i + offset_act_q;
        scale_s1_q <= scale_act_q;
        prod_q     <= sum_q * $signed({1'b0, scale_s1_q});
    end

    // stage 3 shift and clamp to +/- OUT_MAX
    always_comb begin
        shifted = prod_q >>> GAIN_SHIFT;
        if (shifted > OUT_MAX)
            sat = out_t'(OUT_MAX);
        else if (shifted < -OUT_MAX)
            sat = out_t'(-OUT_MAX);
        else
            sat = out_t'(shifted);
        // magnitude fits 4 bits since the clamp is symmetric
        mag = sat[OUT_BITS-1] ? abs_t'(-sat) : abs_t'(sat);
    end

    always_ff @(posedge clk_i) begin
        out_o <= cfg.enable ? sat : '0;
        abs_o <= cfg.enable ? mag : '0;
        gt_o  <= cfg.enable && (sat >= PROBIT_LEVEL);
        lt_o  <= cfg.enable && (sat <= -PROBIT_LEVEL);
    end

endmodule

//--- verilog/lfsr_rms_mux.sv
`timescale 1ns/10ps

module lfsr_rms_mux import agc_pkg::*; #(
    // power of two, 2 to 16
    parameter int NSAMP = 8
) (
    input  logic             clk_i,
    input  logic             agc_rst_i,
    input  logic             sync_i,
    input  abs_t [NSAMP-1:0] abs_i,
    output abs_t             abs_o
);

    localparam int SEL_BITS = $clog2(NSAMP);

    logic [15:0]         lfsr_q;
    logic                feedback;
    logic [SEL_BITS-1:0] sel;

    // fibonacci taps 16 14 13 11
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    // low bits pick the lane
    assign sel = lfsr_q[SEL_BITS-1:0];

    // reload on sync so all channels walk the same sequence
    always_ff @(posedge clk_i) begin
        if (agc_rst_i || sync_i) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    // one registered cycle from lane magnitude to output
    always_ff @(posedge clk_i) begin
        abs_o <= abs_i[sel];
    end

endmodule

//--- verilog/agc_accumulators.sv
`timescale 1ns/10ps

module agc_accumulators import agc_pkg::*; #(
    parameter int      NSAMP    = 8,
    // start value of the square sum, keeps the later sqrt away from zero
    parameter sq_acc_t SQ_RESET = sq_acc_t'(16384)
) (
    input  logic             clk_i,
    input  logic             tick_i,
    input  logic             ce_i,
    input  abs_t             abs_i,
    input  logic [NSAMP-1:0] gt_i,
    input  logic [NSAMP-1:0] lt_i,
    output sq_acc_t          sq_o,
    output pr_acc_t          gt_o,
    output pr_acc_t          lt_o
);

    sq_acc_t sq_term;
    pr_acc_t gt_cnt;
    pr_acc_t lt_cnt;

    // number of set flags in one vector
    function automatic pr_acc_t popcount(input logic [NSAMP-1:0] v);
        pr_acc_t n;
        n = '0;
        for (int i = 0; i < NSAMP; i++) begin
            n = n + pr_acc_t'(v[i]);
        end
        return n;
    endfunction

    // 4 bit magnitude squared, at most 225
    assign sq_term = sq_acc_t'(abs_i) * sq_acc_t'(abs_i);
    assign gt_cnt  = popcount(gt_i);
    assign lt_cnt  = popcount(lt_i);

    // tick starts a new period and wins over ce
    always_ff @(posedge clk_i) begin
        if (tick_i) begin
            sq_o <= SQ_RESET;
            gt_o <= '0;
            lt_o <= '0;
        end else if (ce_i) begin
            sq_o <= sq_o + sq_term;
            gt_o <= gt_o + gt_cnt;
            lt_o <= lt_o + lt_cnt;
        end
    end

endmodule

//--- verilog/agc_core.sv
`timescale 1ns/10ps

module agc_core import agc_pkg::*; #(
    parameter int NSAMP               = 8,
    parameter int TIMESCALE_REDUCTION = 1
) (
    input  logic                clk_i,
    input  logic                agc_rst_i,
    input  sample_t [NSAMP-1:0] rf_dat_i,
    output out_t    [NSAMP-1:0] rf_dat_o,
    // start of an AGC period, clears accumulators
    input  logic                agc_tick_i,
    // accumulate enable
    input  logic                agc_ce_i,
    agc_cfg_if.core             cfg,
    output sq_acc_t             sq_o,
    output pr_acc_t             gt_o,
    output pr_acc_t             lt_o
);

    localparam sq_acc_t SQ_START = sq_acc_t'(16384 / TIMESCALE_REDUCTION);

    abs_t [NSAMP-1:0] abs_vec;
    logic [NSAMP-1:0] gt_vec;
    logic [NSAMP-1:0] lt_vec;
    abs_t             abs_sel;
    logic             lfsr_synced_q;
    logic             lfsr_sync_q;

    for (genvar i = 0; i < NSAMP; i++) begin : g_lane
        agc_dsp u_dsp (
            .clk_i     (clk_i),
            .agc_rst_i (agc_rst_i),
            .cfg       (cfg),
            .dat_i     (rf_dat_i[i]),
            .out_o     (rf_dat_o[i]),
            .abs_o     (abs_vec[i]),
            .gt_o      (gt_vec[i]),
            .lt_o      (lt_vec[i])
        );
    end

    // first tick after reset resyncs the LFSR, later ticks leave it running
    always_ff @(posedge clk_i) begin
        if (agc_rst_i) begin
            lfsr_synced_q <= 1'b0;
            lfsr_sync_q   <= 1'b0;
        end else begin
            lfsr_sync_q <= agc_tick_i && !lfsr_synced_q;
            if (lfsr_sync_q)
                lfsr_synced_q <= 1'b1;
        end
    end

    lfsr_rms_mux #(.NSAMP(NSAMP)) u_mux (
        .clk_i     (clk_i),
        .agc_rst_i (agc_rst_i),
        .sync_i    (lfsr_sync_q),
        .abs_i     (abs_vec),
        .abs_o     (abs_sel)
    );

    agc_accumulators #(.NSAMP(NSAMP), .SQ_RESET(SQ_START)) u_acc (
        .clk_i  (clk_i),
        .tick_i (agc_tick_i),
        .ce_i   (agc_ce_i),
        .abs_i  (abs_sel),
        .gt_i   (gt_vec),
        .lt_i   (lt_vec),
        .sq_o   (sq_o),
        .gt_o   (gt_o),
        .lt_o   (lt_o)
    );

endmodule

//--- verilog/agc_axil_regs.sv
`timescale 1ns/10ps

module agc_axil_regs import agc_pkg::*, agc_reg_pkg::*; (
    input  logic       clk_i,
    input  logic       agc_rst_i,
    input  axil_addr_t s_axil_awaddr_i,
    input  logic       s_axil_awvalid_i,
    output logic       s_axil_awready_o,
    input  axil_data_t s_axil_wdata_i,
    input  logic       s_axil_wvalid_i,
    output logic       s_axil_wready_o,
    output axil_resp_t s_axil_bresp_o,
    output logic       s_axil_bvalid_o,
    input  logic       s_axil_bready_i,
    input  axil_addr_t s_axil_araddr_i,
    input  logic       s_axil_arvalid_i,
    output logic       s_axil_arready_o,
    output axil_data_t s_axil_rdata_o,
    output axil_resp_t s_axil_rresp_o,
    output logic       s_axil_rvalid_o,
    input  logic       s_axil_rready_i,
    agc_cfg_if.regs    cfg,
    input  sq_acc_t    sq_i,
    input  pr_acc_t    gt_i,
    input  pr_acc_t    lt_i
);

    axil_state_e state_q;
    logic        wr_accept;
    logic        rd_accept;
    logic        enable_q;
    scale_t      scale_q;
    offset_t     offset_q;
    axil_data_t  rdata_c;
    axil_data_t  rdata_q;

    // accept only from idle, write wins a tie with a read
    assign wr_accept = (state_q == AXIL_IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_accept = (state_q == AXIL_IDLE) && s_axil_arvalid_i && !wr_accept;

    assign s_axil_awready_o = wr_accept;
    assign s_axil_wready_o  = wr_accept;
    assign s_axil_arready_o = rd_accept;
    assign s_axil_bvalid_o  = (state_q == AXIL_WRESP);
    assign s_axil_rvalid_o  = (state_q == AXIL_RDATA);
    // every address answers OKAY
    assign s_axil_bresp_o   = AXIL_OKAY;
    assign s_axil_rresp_o   = AXIL_OKAY;
    assign s_axil_rdata_o   = rdata_q;

    // strobes fire in the accepting cycle, write data is the pending value
    assign cfg.scale       = s_axil_wdata_i[SCALE_BITS-1:0];
    assign cfg.offset      = s_axil_wdata_i[OFFSET_BITS-1:0];
    assign cfg.scale_load  = wr_accept && (s_axil_awaddr_i == REG_SCALE);
    assign cfg.offset_load = wr_accept && (s_axil_awaddr_i == REG_OFFSET);
    assign cfg.apply       = wr_accept && (s_axil_awaddr_i == REG_CTRL) && s_axil_wdata_i[1];
    assign cfg.enable      = enable_q;

    always_ff @(posedge clk_i) begin
        if (agc_rst_i) begin
            state_q <= AXIL_IDLE;
        end else begin
            case (state_q)
                AXIL_IDLE: begin
                    if (wr_accept)
                        state_q <= AXIL_WRESP;
                    else if (rd_accept)
                        state_q <= AXIL_RDATA;
                end
                // hold response until the master takes it
                AXIL_WRESP: begin
                    if (s_axil_bready_i)
                        state_q <= AXIL_IDLE;
                end
                AXIL_RDATA: begin
                    if (s_axil_rready_i)
                        state_q <= AXIL_IDLE;
                end
                default: state_q <= AXIL_IDLE;
            endcase
        end
    end

    // readback copies of the config, matching the lane reset values
    always_ff @(posedge clk_i) begin
        if (agc_rst_i) begin
            enable_q <= 1'b0;
            scale_q  <= SCALE_UNITY;
            offset_q <= '0;
        end else if (wr_accept) begin
            case (s_axil_awaddr_i)
                REG_CTRL:   enable_q <= s_axil_wdata_i[0];
                REG_SCALE:  scale_q  <= s_axil_wdata_i[SCALE_BITS-1:0];
                REG_OFFSET: offset_q <= s_axil_wdata_i[OFFSET_BITS-1:0];
                default:    ;
            endcase
        end
    end

    // read mux, unmapped reads zero
    always_comb begin
        case (s_axil_araddr_i)
            REG_CTRL:   rdata_c = axil_data_t'(enable_q);
            REG_SCALE:  rdata_c = axil_data_t'(scale_q);
            REG_OFFSET: rdata_c = axil_data_t'($unsigned(offset_q));
            REG_SQ:     rdata_c = axil_data_t'(sq_i);
            REG_GT:     rdata_c = axil_data_t'(gt_i);
            REG_LT:     rdata_c = axil_data_t'(lt_i);
            default:    rdata_c = '0;
        endcase
    end

    // data captured at accept stays stable while rvalid waits
    always_ff @(posedge clk_i) begin
        if (rd_accept)
            rdata_q <= rdata_c;
    end

endmodule

//--- verilog/agc_top.sv
`timescale 1ns/10ps

module agc_top import agc_pkg::*, agc_reg_pkg::*; #(
    parameter int NSAMP               = 8,
    parameter int TIMESCALE_REDUCTION = 1
) (
    input  logic                clk_i,
    input  logic                agc_rst_i,
    input  sample_t [NSAMP-1:0] rf_dat_i,
    output out_t    [NSAMP-1:0] rf_dat_o,
    input  logic                agc_tick_i,
    input  logic                agc_ce_i,
    // AXI4-Lite slave
    input  axil_addr_t          s_axil_awaddr_i,
    input  logic                s_axil_awvalid_i,
    output logic                s_axil_awready_o,
    input  axil_data_t          s_axil_wdata_i,
    input  logic                s_axil_wvalid_i,
    output logic                s_axil_wready_o,
    output axil_resp_t          s_axil_bresp_o,
    output logic                s_axil_bvalid_o,
    input  logic                s_axil_bready_i,
    input  axil_addr_t          s_axil_araddr_i,
    input  logic                s_axil_arvalid_i,
    output logic                s_axil_arready_o,
    output axil_data_t          s_axil_rdata_o,
    output axil_resp_t          s_axil_rresp_o,
    output logic                s_axil_rvalid_o,
    input  logic                s_axil_rready_i
);

    sq_acc_t sq_acc;
    pr_acc_t gt_acc;
    pr_acc_t lt_acc;

    agc_cfg_if cfg_if ();

    agc_core #(.NSAMP(NSAMP), .TIMESCALE_REDUCTION(TIMESCALE_REDUCTION)) u_core (
        .clk_i      (clk_i),
        .agc_rst_i  (agc_rst_i),
        .rf_dat_i   (rf_dat_i),
        .rf_dat_o   (rf_dat_o),
        .agc_tick_i (agc_tick_i),
        .agc_ce_i   (agc_ce_i),
        .cfg        (cfg_if.core),
        .sq_o       (sq_acc),
        .gt_o       (gt_acc),
        .lt_o       (lt_acc)
    );

    agc_axil_regs u_regs (
        .clk_i            (clk_i),
        .agc_rst_i        (agc_rst_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .cfg              (cfg_if.regs),
        .sq_i             (sq_acc),
        .gt_i             (gt_acc),
        .lt_i             (lt_acc)
    );

endmodule

//--- tb/agc_tb.sv
`timescale 1ns/10ps

module agc_tb import agc_pkg::*, agc_reg_pkg::*; ();

    localparam int NSAMP    = 8;
    localparam int NT       = 9;
    localparam int SQ_START = 16384;

    typedef logic [NSAMP*SAMPLE_BITS-1:0] pat_t;

    logic                clk_i;
    logic                agc_rst_i;
    sample_t [NSAMP-1:0] rf_dat_i;
    out_t    [NSAMP-1:0] rf_dat_o;
    logic                agc_tick_i;
    logic                agc_ce_i;
    axil_addr_t          s_axil_awaddr_i;
    logic                s_axil_awvalid_i;
    logic                s_axil_awready_o;
    axil_data_t          s_axil_wdata_i;
    logic                s_axil_wvalid_i;
    logic                s_axil_wready_o;
    axil_resp_t          s_axil_bresp_o;
    logic                s_axil_bvalid_o;
    logic                s_axil_bready_i;
    axil_addr_t          s_axil_araddr_i;
    logic                s_axil_arvalid_i;
    logic                s_axil_arready_o;
    axil_data_t          s_axil_rdata_o;
    axil_resp_t          s_axil_rresp_o;
    logic                s_axil_rvalid_o;
    logic                s_axil_rready_i;

    // stimulus table with one entry per AGC period
    string tname   [NT];
    int    tscale  [NT];
    int    toffset [NT];
    bit    ten     [NT];
    int    tn      [NT];
    pat_t  tpat    [NT];
    int    nent;

    int          mismatches;
    int          failures;
    int          cycles;
    int          limit;
    logic [31:0] seed;
    axil_data_t  rd;

    agc_top #(.NSAMP(NSAMP), .TIMESCALE_REDUCTION(1)) dut_i (.*);

    always #5 clk_i = ~clk_i;

    // run limit counted in rising edges
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int lane_of(input pat_t pat, input int i);
        return int'($signed(pat[i*SAMPLE_BITS +: SAMPLE_BITS]));
    endfunction

    // (sample + offset) times gain, floor shift by 16 then clamp to +/-15
    function automatic int lane_model(input int smp, input int scale, input int offset,
                                      input bit en);
        longint prod;
        int     q;
        prod = longint'(smp + offset) * longint'(scale);
        q    = int'(prod >>> 16);
        if (q > 15)
            q = 15;
        if (q < -15)
            q = -15;
        return en ? q : 0;
    endfunction

    task automatic check_val(input string name, input longint exp, input longint act);
        if (exp != act) begin
            mismatches++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic add_entry(input string name, input int scale, input int offset,
                             input bit en, input int n, input pat_t pat);
        tname[nent]   = name;
        tscale[nent]  = scale;
        toffset[nent] = offset;
        ten[nent]     = en;
        tn[nent]      = n;
        tpat[nent]    = pat;
        nent++;
    endtask

    task automatic build_table();
        pat_t rp;
        // lane 7 on the left and negative lanes in two's complement hex
        add_entry("unity_equal", 65536, 0, 1, 20, {NSAMP{12'h005}});
        add_entry("equal_negative", 65536, 0, 1, 30, {NSAMP{12'hFF5}});
        add_entry("half_gain_pos_offset", 32768, 4, 1, 24,
                  {12'h01E, 12'h000, 12'hFFB, 12'h005, 12'hFF5, 12'h00B, 12'hFEC, 12'h014});
        add_entry("double_gain_clamp", 131071, 0, 1, 16,
                  {12'h000, 12'h001, 12'hFF9, 12'h007, 12'hFFD, 12'h003, 12'hFF6, 12'h00A});
        add_entry("negative_offset", 65536, -100, 1, 30,
                  {12'h000, 12'h050, 12'h073, 12'h06C, 12'h082, 12'h05A, 12'h05F, 12'h064});
        add_entry("probit_pattern", 65536, 0, 1, 40,
                  {12'h009, 12'h000, 12'hFF4, 12'h00F, 12'hFF9, 12'h007, 12'hFF8, 12'h008});
        add_entry("enable_low", 65536, 0, 0, 12, {NSAMP{12'h009}});
        // random lanes within the clamp range
        for (int i = 0; i < NSAMP; i++) begin
            seed = lcg_next(seed);
            rp[i*SAMPLE_BITS +: SAMPLE_BITS] = SAMPLE_BITS'(int'(seed[23:16] % 31) - 15);
        end
        add_entry("random_lanes", 65536, 0, 1, 64, rp);
        // same lanes again since the second tick leaves the LFSR running
        add_entry("random_retick", 65536, 0, 1, 64, rp);
    endtask

    // write with bready held low for hold cycles once bvalid shows
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int hold);
        @(negedge clk_i);
        s_axil_awaddr_i  = addr;
        s_axil_awvalid_i = 1'b1;
        s_axil_wdata_i   = data;
        s_axil_wvalid_i  = 1'b1;
        s_axil_bready_i  = (hold == 0);
        @(negedge clk_i);
        while (!s_axil_bvalid_o)
            @(negedge clk_i);
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i  = 1'b0;
        check_val("write response", AXIL_OKAY, s_axil_bresp_o);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk_i);
            if (!s_axil_bvalid_o) begin
                failures++;
                $display("bvalid dropped while bready was held low");
            end
        end
        s_axil_bready_i = 1'b1;
    endtask

    // read with rready held low for hold cycles while the data must hold still
    task automatic axil_read(input axil_addr_t addr, input int hold, output axil_data_t data);
        @(negedge clk_i);
        s_axil_araddr_i  = addr;
        s_axil_arvalid_i = 1'b1;
        s_axil_rready_i  = (hold == 0);
        @(negedge clk_i);
        while (!s_axil_rvalid_o)
            @(negedge clk_i);
        s_axil_arvalid_i = 1'b0;
        data = s_axil_rdata_o;
        check_val("read response", AXIL_OKAY, s_axil_rresp_o);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk_i);
            if (!s_axil_rvalid_o || s_axil_rdata_o != data) begin
                failures++;
                $display("read data not held while rready was low");
            end
        end
        s_axil_rready_i = 1'b1;
    endtask

    task automatic check_lanes(input string name, input int scale, input int offset,
                               input bit en, input pat_t pat);
        for (int i = 0; i < NSAMP; i++) begin
            check_val($sformatf("%s lane %0d", name, i),
                      lane_model(lane_of(pat, i), scale, offset, en), $signed(rf_dat_o[i]));
        end
    endtask

    // one AGC period to configure, check outputs, accumulate and read back
    task automatic run_entry(input int k);
        int o;
        int ngt;
        int nlt;
        int sq_min;
        int sq_max;
        ngt    = 0;
        nlt    = 0;
        sq_min = 1000;
        sq_max = -1;
        for (int i = 0; i < NSAMP; i++) begin
            o = lane_model(lane_of(tpat[k], i), tscale[k], toffset[k], ten[k]);
            if (o >= 8)
                ngt++;
            if (o <= -8)
                nlt++;
            if (o * o < sq_min)
                sq_min = o * o;
            if (o * o > sq_max)
                sq_max = o * o;
        end
        axil_write(REG_SCALE, axil_data_t'(tscale[k]), 0);
        axil_write(REG_OFFSET, axil_data_t'(toffset[k]), 0);
        // apply together with the enable level
        axil_write(REG_CTRL, {30'd0, 1'b1, ten[k]}, 0);
        rf_dat_i = tpat[k];
        repeat (6) @(negedge clk_i);
        check_lanes(tname[k], tscale[k], toffset[k], ten[k], tpat[k]);
        agc_tick_i = 1'b1;
        @(negedge clk_i);
        agc_tick_i = 1'b0;
        agc_ce_i   = 1'b1;
        repeat (tn[k]) @(negedge clk_i);
        agc_ce_i = 1'b0;
        repeat (6) @(negedge clk_i);
        axil_read(REG_SQ, 0, rd);
        // equal magnitudes give an exact sum and mixed ones a range
        if (sq_min == sq_max) begin
            check_val({tname[k], " square sum"}, SQ_START + tn[k] * sq_min, rd);
        end else if (rd < SQ_START + tn[k] * sq_min || rd > SQ_START + tn[k] * sq_max) begin
            mismatches++;
            $display("mismatch %s square sum: expected %0d..%0d, actual %0d", tname[k],
                     SQ_START + tn[k] * sq_min, SQ_START + tn[k] * sq_max, rd);
        end
        axil_read(REG_GT, 0, rd);
        check_val({tname[k], " gt count"}, tn[k] * ngt, rd);
        axil_read(REG_LT, 0, rd);
        check_val({tname[k], " lt count"}, tn[k] * nlt, rd);
    endtask

    initial begin
        clk_i            = 1'b0;
        agc_rst_i        = 1'b1;
        rf_dat_i         = '0;
        agc_tick_i       = 1'b0;
        agc_ce_i         = 1'b0;
        s_axil_awaddr_i  = '0;
        s_axil_awvalid_i = 1'b0;
        s_axil_wdata_i   = '0;
        s_axil_wvalid_i  = 1'b0;
        s_axil_bready_i  = 1'b0;
        s_axil_araddr_i  = '0;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i  = 1'b0;
        mismatches       = 0;
        failures         = 0;
        cycles           = 0;
        nent             = 0;
        seed             = 32'h8f51f374;
        build_table();
        limit = 200 * NT;
        for (int k = 0; k < NT; k++)
            limit += tn[k];

        repeat (8) @(negedge clk_i);
        agc_rst_i = 1'b0;
        @(negedge clk_i);
        // bus idle and lanes quiet after reset
        check_val("reset bvalid", 0, s_axil_bvalid_o);
        check_val("reset rvalid", 0, s_axil_rvalid_o);
        check_val("reset awready", 0, s_axil_awready_o);
        check_val("reset wready", 0, s_axil_wready_o);
        check_val("reset arready", 0, s_axil_arready_o);
        check_lanes("reset output", 65536, 0, 0, '0);
        axil_read(REG_CTRL, 0, rd);
        check_val("reset ctrl", 0, rd);
        axil_read(REG_SCALE, 0, rd);
        check_val("reset scale", 65536, rd);
        axil_read(REG_OFFSET, 0, rd);
        check_val("reset offset", 0, rd);
        axil_read(8'h18, 0, rd);
        check_val("unmapped read", 0, rd);

        // pending gain and offset stay out of the lanes until apply
        axil_write(REG_CTRL, 32'd1, 0);
        rf_dat_i = {NSAMP{12'h004}};
        repeat (6) @(negedge clk_i);
        check_lanes("enable unity", 65536, 0, 1, rf_dat_i);
        axil_write(REG_SCALE, 32'd32768, 0);
        axil_write(REG_OFFSET, 32'd2, 0);
        repeat (6) @(negedge clk_i);
        check_lanes("pending only", 65536, 0, 1, rf_dat_i);
        axil_write(REG_CTRL, 32'd3, 0);
        // accepted one edge back so the new gain shows on the third edge after
        repeat (2) @(negedge clk_i);
        check_lanes("apply latency old", 65536, 0, 1, rf_dat_i);
        @(negedge clk_i);
        check_lanes("apply latency new", 32768, 2, 1, rf_dat_i);

        for (int k = 0; k < NT; k++)
            run_entry(k);

        // stalled responses and then a normal transaction
        axil_write(REG_SCALE, 32'h0C000, 4);
        axil_read(REG_SCALE, 5, rd);
        check_val("stalled scale read", 32'h0C000, rd);
        axil_read(REG_CTRL, 0, rd);
        check_val("ctrl after stall", 1, rd);

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/agc_pkg.sv
verilog/agc_reg_pkg.sv
verilog/agc_cfg_if.sv
verilog/agc_dsp.sv
verilog/lfsr_rms_mux.sv
verilog/agc_accumulators.sv
verilog/agc_core.sv
verilog/agc_axil_regs.sv
verilog/agc_top.sv
tb/agc_tb.sv

//--- Bender.yml
package:
  name: agc_channel

sources:
  - verilog/agc_pkg.sv
  - verilog/agc_reg_pkg.sv
  - verilog/agc_cfg_if.sv
  - verilog/agc_dsp.sv
  - verilog/lfsr_rms_mux.sv
  - verilog/agc_accumulators.sv
  - verilog/agc_core.sv
  - verilog/agc_axil_regs.sv
  - verilog/agc_top.sv
  - target: test
    files:
      - tb/agc_tb.sv
